// File: logic_core.f
+incdir+verilog
verilog/mips_pkg.sv
verilog/inst_fifo.sv
verilog/regfile.sv
verilog/id.sv
verilog/ex.sv
verilog/logic_core.sv
tb/logic_core_checker.sv
tb/logic_core_tb.sv

// File: Makefile
# Verilator build and run of the logic_core testbench

all: run

build:
	verilator --binary --timing -Wno-fatal -f logic_core.f --top-module logic_core_tb -o logic_core_sim

run: build
	./obj_dir/logic_core_sim | tee sim.log
	grep -q "Test completed successfully" sim.log

lint:
	verilator --lint-only --timing -f logic_core.f --top-module logic_core

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// File: tb/logic_core_tb.sv
`default_nettype none

`include "mips_macros.svh"

module logic_core_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import mips_pkg::*;

    localparam int NUM_INST    = 47 + 36 + 40 + 40 + 30 + 24;   // sum of test lengths
    localparam int CYCLE_LIMIT = 8 * NUM_INST + 100;
    localparam logic [5:0] OP_UNDEF = 6'b100011;   // load word is not in this core
    localparam logic [5:0] FN_UNDEF = 6'b100000;   // add is not in this core
    localparam logic [5:0] LOGIC_FN [4] = '{`MIPS_FN_OR, `MIPS_FN_AND,
                                            `MIPS_FN_XOR, `MIPS_FN_NOR};
    localparam logic [5:0] SHIFT_FN [4] = '{`MIPS_FN_SLL, `MIPS_FN_SRL,
                                            `MIPS_FN_SRA, `MIPS_FN_SRA};
    localparam logic [5:0] IMM_OP [4] = '{`MIPS_OP_ORI, `MIPS_OP_ANDI,
                                          `MIPS_OP_XORI, `MIPS_OP_LUI};

    logic        clk;
    logic        arst_n;
    logic        inst_valid;
    inst_u       inst;
    logic        credit;
    wb_t         wb;
    logic [31:0] lfsr = 32'hac8819db;
    int          credits;
    int          sent;
    int          returned;
    int          tb_errors;
    int          err_mark;
    int          cycles;
    int          tests_run;
    int          bad_tests;
    int          pending;
    int          checks;
    int          chk_errors;

    logic_core dut_i (.clk_i(clk), .arst_n_i(arst_n), .inst_valid_i(inst_valid),
                      .inst_i(inst), .credit_o(credit), .wb_o(wb));

    logic_core_checker chk_i (.clk_i(clk), .arst_n_i(arst_n), .inst_valid_i(inst_valid),
                              .inst_i(inst), .wb_i(wb), .pending_o(pending),
                              .checks_o(checks), .errors_o(chk_errors));

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, %0d write-backs never arrived", cycles, pending);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);   // taps 32,22,2,1
        end
        return r;
    endfunction

    function automatic logic [4:0] any_reg();
        return 5'(rand_bits(3));                 // r0..r7 keeps hazards frequent
    endfunction

    function automatic logic [4:0] dest_reg();
        return 5'(1 + rand_bits(3) % 7);
    endfunction

    // kind 0 logic R-type, 1 shift R-type, else I-type with rd as its rt
    function automatic logic [31:0] make_inst(input int kind, input logic [4:0] rs, rt, rd);
        logic [1:0] sel;
        sel = 2'(rand_bits(2));
        case (kind)
            0:       return {`MIPS_OP_SPECIAL, rs, rt, rd, 5'd0, LOGIC_FN[sel]};
            1:       return {`MIPS_OP_SPECIAL, 5'd0, rt, rd, 5'(rand_bits(5)), SHIFT_FN[sel]};
            default: return {IMM_OP[sel], rs, rd, 16'(rand_bits(16))};
        endcase
    endfunction

    task automatic tick();
        @(negedge clk);
        if (credit) begin
            credits++;
            returned++;
        end
        if (credits > `MIPS_FIFO_DEPTH) begin
            tb_errors++;
            $display("credit_o returned a credit for an entry that was never sent");
            credits = `MIPS_FIFO_DEPTH;
        end
    endtask

    task automatic send(input logic [31:0] w, input bit may_idle);
        while (credits == 0 || (may_idle && rand_bits(2) == 0)) begin
            inst_valid = 1'b0;
            tick();
        end
        inst_valid = 1'b1;
        inst       = w;
        credits--;
        sent++;
        tick();
        inst_valid = 1'b0;
    endtask

    task automatic start_test(input string name);
        chk_i.begin_test(name);
        err_mark = tb_errors + chk_errors;
    endtask

    task automatic end_test(input string name);
        int errs;
        while (pending != 0) begin
            tick();
        end
        if (returned != sent || credits != `MIPS_FIFO_DEPTH || checks != sent) begin
            tb_errors++;
            $display({"FAILED %s: expected %0d credits back, %0d write-backs, %0d credits held;",
                      " actual %0d, %0d, %0d"},
                     name, sent, sent, `MIPS_FIFO_DEPTH, returned, checks, credits);
        end
        errs = tb_errors + chk_errors - err_mark;
        tests_run++;
        if (errs != 0) begin
            bad_tests++;
        end
        $display("%-18s done, %0d errors", name, errs);
    endtask

    initial begin
        logic [4:0] last;
        logic [4:0] prev;
        logic [4:0] src;
        logic [4:0] dest;
        clk        = 1'b0;
        arst_n     = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        credits    = `MIPS_FIFO_DEPTH;
        for (int k = 0; k < 3; k++) begin
            @(negedge clk);
            if (credit || wb.valid || wb.we) begin
                tb_errors++;
                $display("credit_o, wb_o.valid or wb_o.we high with nothing sent, cycle %0d", k);
            end
            arst_n = (k >= 1);                   // released after two cycles
        end

        start_test("logic_rtype");
        for (int k = 1; k < 8; k++) begin
            send({`MIPS_OP_ORI, any_reg(), 5'(k), 16'(rand_bits(16))}, 1'b1);
        end
        repeat (40) send(make_inst(0, any_reg(), any_reg(), dest_reg()), 1'b1);
        end_test("logic_rtype");

        start_test("shift_rtype");
        for (int k = 1; k < 4; k++) begin
            send({`MIPS_OP_LUI, 5'd0, 5'(k), 16'(rand_bits(16))}, 1'b1);   // sign bit often set
            send({`MIPS_OP_ORI, 5'(k), 5'(k), 16'(rand_bits(16))}, 1'b1);
        end
        repeat (30) send(make_inst(1, 5'd0, any_reg(), dest_reg()), 1'b1);
        end_test("shift_rtype");

        start_test("immediate_ops");
        repeat (40) send(make_inst(2, any_reg(), 5'd0, dest_reg()), 1'b1);
        end_test("immediate_ops");

        start_test("back_to_back_deps");
        last = dest_reg();
        prev = dest_reg();
        repeat (40) begin
            src  = rand_bits(1) ? last : prev;
            dest = dest_reg();
            send(make_inst(int'(rand_bits(2) % 3), src, last, dest), 1'b1);
            prev = last;
            last = dest;
        end
        end_test("back_to_back_deps");

        start_test("credit_flow");
        repeat (30) begin
            send(make_inst(int'(rand_bits(2) % 3), any_reg(), any_reg(), dest_reg()), 1'b0);
        end
        end_test("credit_flow");

        start_test("zero_and_nop");
        repeat (24) begin
            case (rand_bits(2))
                0: send(make_inst(int'(rand_bits(2) % 3), any_reg(), any_reg(), 5'd0), 1'b1);
                1: send({OP_UNDEF, any_reg(), dest_reg(), 16'(rand_bits(16))}, 1'b1);
                2: send({`MIPS_OP_SPECIAL, any_reg(), any_reg(), dest_reg(), 5'd0, FN_UNDEF}, 1'b1);
                default: send({`MIPS_OP_SPECIAL, 10'd0, dest_reg(), 5'd0, `MIPS_FN_OR}, 1'b1);
            endcase
        end
        end_test("zero_and_nop");

        $display("%0d tests, %0d with errors, %0d write-backs checked, %0d errors",
                 tests_run, bad_tests, checks, tb_errors + chk_errors);
        if (tb_errors + chk_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/logic_core_checker.sv
`default_nettype none

`include "mips_macros.svh"

module logic_core_checker (
    input  wire                  clk_i,
    input  wire                  arst_n_i,
    input  wire                  inst_valid_i,
    input  wire mips_pkg::inst_u inst_i,
    input  wire mips_pkg::wb_t   wb_i,
    output int                   pending_o,
    output int                   checks_o,
    output int                   errors_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import mips_pkg::*;

    logic [`MIPS_XLEN-1:0] regs [`MIPS_REG_NUM];   // reference register file
    wb_t                   exp_q [$];
    string                 test_name = "reset";

    task automatic begin_test(input string name);
        test_name = name;
    endtask

    // expected write-back of one word from the current model state
    function automatic wb_t predict(input logic [31:0] w);
        wb_t         e;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        a   = regs[w[25:21]];
        b   = regs[w[20:16]];
        imm = {16'h0, w[15:0]};
        e   = '{valid: 1'b1, waddr: w[20:16], we: 1'b1, data: '0};
        case (w[31:26])
            `MIPS_OP_ORI:  e.data = a | imm;
            `MIPS_OP_ANDI: e.data = a & imm;
            `MIPS_OP_XORI: e.data = a ^ imm;
            `MIPS_OP_LUI:  e.data = {w[15:0], 16'h0};
            `MIPS_OP_SPECIAL: begin
                e.waddr = w[15:11];
                case (w[5:0])
                    `MIPS_FN_OR:  e.data = a | b;
                    `MIPS_FN_AND: e.data = a & b;
                    `MIPS_FN_XOR: e.data = a ^ b;
                    `MIPS_FN_NOR: e.data = ~(a | b);
                    `MIPS_FN_SLL: e.data = b << w[10:6];
                    `MIPS_FN_SRL: e.data = b >> w[10:6];
                    `MIPS_FN_SRA: e.data = (b >> w[10:6])
                                         | (b[31] ? ~(32'hffffffff >> w[10:6]) : 32'h0);
                    default:      e.we = 1'b0;
                endcase
            end
            default: e.we = 1'b0;                // undefined encodings never write
        endcase
        return e;
    endfunction

    always @(posedge clk_i or negedge arst_n_i) begin
        wb_t e;
        if (!arst_n_i) begin
            for (int k = 0; k < `MIPS_REG_NUM; k++) begin
                regs[k] = '0;
            end
            exp_q.delete();
        end else begin
            if (wb_i.valid) begin
                if (exp_q.size() == 0) begin
                    errors_o++;
                    $display("%s: write-back beat with no instruction outstanding", test_name);
                end else begin
                    e = exp_q.pop_front();
                    checks_o++;
                    if (wb_i.we !== e.we
                        || (e.we && (wb_i.waddr !== e.waddr || wb_i.data !== e.data))) begin
                        errors_o++;
                        $display("FAILED %s: expected we=%0b r%0d=%h, actual we=%0b r%0d=%h",
                                 test_name, e.we, e.waddr, e.data, wb_i.we, wb_i.waddr,
                                 wb_i.data);
                    end
                end
            end
            if (inst_valid_i) begin
                e = predict(inst_i);
                if (e.we && e.waddr != '0) begin
                    regs[e.waddr] = e.data;      // r0 stays zero
                end
                exp_q.push_back(e);
            end
        end
        pending_o = exp_q.size();
    end

endmodule

`default_nettype wire

// File: verilog/logic_core.sv
`default_nettype none

`include "mips_macros.svh"

module logic_core (
    input  wire                  clk_i,
    input  wire                  arst_n_i,
    input  wire                  inst_valid_i,
    input  wire mips_pkg::inst_u inst_i,
    output logic                 credit_o,
    output mips_pkg::wb_t        wb_o
);
    import mips_pkg::*;

    wire                                   dec_valid;
    wire inst_u                            dec_inst;
    wire [$clog2(`MIPS_REG_NUM)-1:0]       raddr1;
    wire [$clog2(`MIPS_REG_NUM)-1:0]       raddr2;
    wire [`MIPS_XLEN-1:0]                  rdata1;
    wire [`MIPS_XLEN-1:0]                  rdata2;
    wire ex_req_t                          ex_req;
    wire wb_t                              ex_fwd;

    inst_fifo fifo_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .push_i   (inst_valid_i),
        .data_i   (inst_i),
        .valid_o  (dec_valid),
        .data_o   (dec_inst),
        .credit_o (credit_o)
    );

    id id_i (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .inst_valid_i (dec_valid),
        .inst_i       (dec_inst),
        .raddr1_o     (raddr1),
        .raddr2_o     (raddr2),
        .rdata1_i     (rdata1),
        .rdata2_i     (rdata2),
        .ex_fwd_i     (ex_fwd),
        .wb_i         (wb_o),
        .req_o        (ex_req)
    );

    ex ex_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (ex_req),
        .fwd_o    (ex_fwd),
        .wb_o     (wb_o)
    );

    regfile rf_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .wb_i     (wb_o),
        .raddr1_i (raddr1),
        .raddr2_i (raddr2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

endmodule

`default_nettype wire

// File: verilog/ex.sv
`default_nettype none

`include "mips_macros.svh"

module ex (
    input  wire                  clk_i,
    input  wire                  arst_n_i,
    input  wire mips_pkg::ex_req_t req_i,
    output mips_pkg::wb_t        fwd_o,
    output mips_pkg::wb_t        wb_o
);
    import mips_pkg::*;

    logic [`MIPS_XLEN-1:0] logic_res;
    logic [`MIPS_XLEN-1:0] shift_res;
    logic [`MIPS_XLEN-1:0] alu_res;

    // logic group
    always_comb begin
        case (req_i.aluop)
            ALU_OR:  logic_res = req_i.src1 | req_i.src2;
            ALU_AND: logic_res = req_i.src1 & req_i.src2;
            ALU_XOR: logic_res = req_i.src1 ^ req_i.src2;
            ALU_NOR: logic_res = ~(req_i.src1 | req_i.src2);
            default: logic_res = '0;
        endcase
    end

    // shift group, rt value moved by shamt
    always_comb begin
        case (req_i.aluop)
            ALU_SLL: shift_res = req_i.src2 << req_i.shamt;
            ALU_SRL: shift_res = req_i.src2 >> req_i.shamt;
            ALU_SRA: shift_res = $signed(req_i.src2) >>> req_i.shamt;   // sign fill
            default: shift_res = '0;
        endcase
    end

    always_comb begin
        case (req_i.alu_sel)
            SEL_LOGIC: alu_res = logic_res;
            SEL_SHIFT: alu_res = shift_res;
            default:   alu_res = '0;
        endcase
    end

    always_comb begin
        fwd_o.valid = req_i.valid;
        fwd_o.waddr = req_i.waddr;
        fwd_o.we    = req_i.we;
        fwd_o.data  = alu_res;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_o.valid <= 1'b0;
            wb_o.we    <= 1'b0;
        end else begin
            wb_o <= fwd_o;
        end
    end

endmodule

`default_nettype wire

// File: verilog/id.sv
`default_nettype none

`include "mips_macros.svh"

module id (
    input  wire                                   clk_i,
    input  wire                                   arst_n_i,
    input  wire                                   inst_valid_i,
    input  wire mips_pkg::inst_u                  inst_i,
    output logic [$clog2(`MIPS_REG_NUM)-1:0]      raddr1_o,
    output logic [$clog2(`MIPS_REG_NUM)-1:0]      raddr2_o,
    input  wire [`MIPS_XLEN-1:0]                  rdata1_i,
    input  wire [`MIPS_XLEN-1:0]                  rdata2_i,
    input  wire mips_pkg::wb_t                    ex_fwd_i,
    input  wire mips_pkg::wb_t                    wb_i,
    output mips_pkg::ex_req_t                     req_o
);
    import mips_pkg::*;

    alu_op_e                aluop;
    alu_sel_e               alusel;
    logic                   use_imm;
    logic                   is_lui;
    logic [`MIPS_XLEN-1:0]  imm;
    logic [`MIPS_XLEN-1:0]  op1;
    logic [`MIPS_XLEN-1:0]  op2;
    ex_req_t                req_d;

    // youngest in-flight writer wins, then the register file
    function automatic logic [`MIPS_XLEN-1:0] fwd_sel(
        input logic [$clog2(`MIPS_REG_NUM)-1:0] addr,
        input logic [`MIPS_XLEN-1:0]            rf_data,
        input wb_t                              ex_w,
        input wb_t                              wb_w
    );
        logic [`MIPS_XLEN-1:0] res;
        res = rf_data;
        if (addr != '0) begin
            if (ex_w.valid && ex_w.we && ex_w.waddr == addr) begin
                res = ex_w.data;
            end else if (wb_w.valid && wb_w.we && wb_w.waddr == addr) begin
                res = wb_w.data;
            end
        end
        return res;
    endfunction

    assign raddr1_o = inst_i.r.rs;
    assign raddr2_o = inst_i.r.rt;

    always_comb begin
        aluop  = ALU_NOP;
        is_lui = 1'b0;
        case (inst_i.r.opcode)
            `MIPS_OP_SPECIAL: begin
                case (inst_i.r.funct)
                    `MIPS_FN_OR:  aluop = ALU_OR;
                    `MIPS_FN_AND: aluop = ALU_AND;
                    `MIPS_FN_XOR: aluop = ALU_XOR;
                    `MIPS_FN_NOR: aluop = ALU_NOR;
                    `MIPS_FN_SLL: aluop = ALU_SLL;
                    `MIPS_FN_SRL: aluop = ALU_SRL;
                    `MIPS_FN_SRA: aluop = ALU_SRA;
                    default:      aluop = ALU_NOP;
                endcase
            end
            `MIPS_OP_ORI:  aluop = ALU_OR;
            `MIPS_OP_ANDI: aluop = ALU_AND;
            `MIPS_OP_XORI: aluop = ALU_XOR;
            `MIPS_OP_LUI: begin
                aluop  = ALU_OR;              // 0 | (imm16 << 16)
                is_lui = 1'b1;
            end
            default:       aluop = ALU_NOP;
        endcase
    end

    always_comb begin
        if (aluop == ALU_NOP) begin
            alusel = SEL_NOP;
        end else if (aluop inside {ALU_SLL, ALU_SRL, ALU_SRA}) begin
            alusel = SEL_SHIFT;
        end else begin
            alusel = SEL_LOGIC;
        end
    end

    assign use_imm = (inst_i.r.opcode != `MIPS_OP_SPECIAL);
    assign imm     = is_lui ? {inst_i.i.imm16, {(`MIPS_XLEN-16){1'b0}}}
                            : {{(`MIPS_XLEN-16){1'b0}}, inst_i.i.imm16};

    assign op1 = fwd_sel(inst_i.r.rs, rdata1_i, ex_fwd_i, wb_i);
    assign op2 = fwd_sel(inst_i.r.rt, rdata2_i, ex_fwd_i, wb_i);

    always_comb begin
        req_d.valid   = inst_valid_i;
        req_d.aluop   = aluop;
        req_d.alu_sel = alusel;
        req_d.src1    = is_lui ? '0 : op1;
        req_d.src2    = use_imm ? imm : op2;
        req_d.shamt   = inst_i.r.shamt;
        req_d.waddr   = use_imm ? inst_i.i.rt : inst_i.r.rd;   // rt for I-type
        req_d.we      = inst_valid_i && (aluop != ALU_NOP);
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_o.valid <= 1'b0;
            req_o.we    <= 1'b0;
        end else begin
            req_o <= req_d;
        end
    end

endmodule

`default_nettype wire

// File: verilog/regfile.sv
`default_nettype none

`include "mips_macros.svh"

module regfile (
    input  wire                                   clk_i,
    input  wire                                   arst_n_i,
    input  wire mips_pkg::wb_t                    wb_i,
    input  wire [$clog2(`MIPS_REG_NUM)-1:0]       raddr1_i,
    input  wire [$clog2(`MIPS_REG_NUM)-1:0]       raddr2_i,
    output logic [`MIPS_XLEN-1:0]                 rdata1_o,
    output logic [`MIPS_XLEN-1:0]                 rdata2_o
);

    logic [`MIPS_XLEN-1:0] regs [`MIPS_REG_NUM];
    logic                  wr_en;

    assign wr_en = wb_i.valid && wb_i.we && (wb_i.waddr != '0);   // r0 writes dropped

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int k = 0; k < `MIPS_REG_NUM; k++) begin
                regs[k] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_i.waddr] <= wb_i.data;
        end
    end

    always_comb begin
        if (raddr1_i == '0) begin
            rdata1_o = '0;
        end else begin
            rdata1_o = regs[raddr1_i];
        end
    end

    always_comb begin
        if (raddr2_i == '0) begin
            rdata2_o = '0;
        end else begin
            rdata2_o = regs[raddr2_i];
        end
    end

endmodule

`default_nettype wire

// File: verilog/inst_fifo.sv
`default_nettype none

`include "mips_macros.svh"

module inst_fifo (
    input  wire             clk_i,
    input  wire             arst_n_i,
    input  wire             push_i,
    input  wire mips_pkg::inst_u data_i,
    output logic            valid_o,
    output mips_pkg::inst_u data_o,
    output logic            credit_o
);
    import mips_pkg::*;

    localparam int AW = $clog2(`MIPS_FIFO_DEPTH);

    inst_u        mem [`MIPS_FIFO_DEPTH];
    logic [AW:0]  wptr;                       // extra bit tells full from empty
    logic [AW:0]  rptr;
    logic         pop;

    assign pop = (wptr != rptr);              // drain whenever something is held

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem[wptr[AW-1:0]] <= data_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wptr     <= '0;
            rptr     <= '0;
            valid_o  <= 1'b0;
            credit_o <= 1'b0;
        end else begin
            if (push_i) begin
                wptr <= wptr + 1'b1;
            end
            if (pop) begin
                rptr <= rptr + 1'b1;
            end
            valid_o  <= pop;
            credit_o <= pop;                  // one credit back per entry freed
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop) begin
            data_o <= mem[rptr[AW-1:0]];
        end
    end

endmodule

`default_nettype wire

// File: verilog/mips_pkg.sv
`default_nettype none

`include "mips_macros.svh"

package mips_pkg;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        logic [5:0]  funct;
    } r_inst_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_inst_t;

    // same word, two decodings
    typedef union packed {
        r_inst_t r;
        i_inst_t i;
    } inst_u;

    typedef enum logic [2:0] {
        ALU_NOP, ALU_OR, ALU_AND, ALU_XOR, ALU_NOR, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_e;

    typedef enum logic [1:0] {
        SEL_NOP, SEL_LOGIC, SEL_SHIFT
    } alu_sel_e;

    typedef struct packed {
        logic                              valid;
        alu_op_e                           aluop;
        alu_sel_e                          alu_sel;
        logic [`MIPS_XLEN-1:0]             src1;
        logic [`MIPS_XLEN-1:0]             src2;
        logic [4:0]                        shamt;
        logic [$clog2(`MIPS_REG_NUM)-1:0]  waddr;
        logic                              we;
    } ex_req_t;

    typedef struct packed {
        logic                              valid;
        logic [$clog2(`MIPS_REG_NUM)-1:0]  waddr;
        logic                              we;
        logic [`MIPS_XLEN-1:0]             data;
    } wb_t;

endpackage

`default_nettype wire

// File: verilog/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

`define MIPS_XLEN        32
`define MIPS_REG_NUM     32
// also the number of credits the sender starts with
`define MIPS_FIFO_DEPTH  4

// major opcodes
`define MIPS_OP_SPECIAL  6'b000000
`define MIPS_OP_ANDI     6'b001100
`define MIPS_OP_ORI      6'b001101
`define MIPS_OP_XORI     6'b001110
`define MIPS_OP_LUI      6'b001111

// funct codes under SPECIAL
`define MIPS_FN_SLL      6'b000000
`define MIPS_FN_SRL      6'b000010
`define MIPS_FN_SRA      6'b000011
`define MIPS_FN_AND      6'b100100
`define MIPS_FN_OR       6'b100101
`define MIPS_FN_XOR      6'b100110
`define MIPS_FN_NOR      6'b100111

`endif
